// ==== design/be_pkg.sv ====
/*
 * Shared widths, enums and structs of the back-end issue stage.
 * Imported by every module and by the testbench.
 */
package be_pkg;

   // Front-end virtual address width
   localparam int vaddr_width_c = 39;
   // Data width for PC and immediates
   localparam int reg_data_width_c = 64;
   localparam int itag_width_c = 8;
   localparam int instr_width_c = 32;
   localparam int reg_addr_width_c = 5;
   // Opaque branch predictor state forwarded untouched
   localparam int bmeta_width_c = 32;

   typedef enum logic
   {
      e_fe_fetch = 1'b0,
      e_fe_exception = 1'b1
   } fe_msg_type_e;

   typedef enum logic [1:0]
   {
      e_instr_misaligned = 2'd0,
      e_instr_access_fault = 2'd1,
      e_instr_page_fault = 2'd2,
      e_itlb_miss = 2'd3
   } fe_exc_code_e;

   // RV64 major opcodes, instruction bits 6:0
   typedef enum logic [6:0]
   {
      e_op_lui = 7'b0110111,
      e_op_auipc = 7'b0010111,
      e_op_jal = 7'b1101111,
      e_op_jalr = 7'b1100111,
      e_op_branch = 7'b1100011,
      e_op_load = 7'b0000011,
      e_op_store = 7'b0100011,
      e_op_imm = 7'b0010011,
      e_op_imm_32 = 7'b0011011,
      e_op_op = 7'b0110011,
      e_op_op_32 = 7'b0111011,
      e_op_system = 7'b1110011
   } rv64_opcode_e;

   // One fetch-queue message
   typedef struct packed
   {
      fe_msg_type_e msg_type;
      // Fetch PC, or faulting address on exception
      logic [vaddr_width_c-1:0] pc;
      // Compressed instruction sits in the low half
      logic [instr_width_c-1:0] instr;
      fe_exc_code_e exc_code;
      logic [bmeta_width_c-1:0] branch_metadata;
   } fe_queue_s;

   // Source operand predecode
   typedef struct packed
   {
      logic irs1_v;
      logic irs2_v;
      logic [reg_addr_width_c-1:0] rs1_addr;
      logic [reg_addr_width_c-1:0] rs2_addr;
   } src_info_s;

   typedef struct packed
   {
      logic [itag_width_c-1:0] itag;
      logic [reg_data_width_c-1:0] pc;
      logic exception_not_instr;
      fe_exc_code_e exc_code;
   } instr_metadata_s;

   // Packet handed to the execution pipe
   typedef struct packed
   {
      instr_metadata_s instr_metadata;
      logic [bmeta_width_c-1:0] branch_metadata;
      // Always the 32-bit form
      logic [instr_width_c-1:0] instr;
      logic is_compressed;
      logic irs1_v;
      logic irs2_v;
      // FP reads never predecoded, always low
      logic frs1_v;
      logic frs2_v;
      logic [reg_addr_width_c-1:0] rs1_addr;
      logic [reg_addr_width_c-1:0] rs2_addr;
      logic [reg_data_width_c-1:0] imm;
   } issue_pkt_s;

endpackage

// ==== design/rvc_expander.sv ====
/*
 * Expands a subset of RVC instructions to their 32-bit encodings.
 * Purely combinational, sits in front of both decoders.
 */
`timescale 1ns/100ps

module rvc_expander
(
   input  logic [be_pkg::instr_width_c-1:0] instr_i,
   output logic [be_pkg::instr_width_c-1:0] expanded_instr_o,
   output logic                             is_compressed_o
);

   import be_pkg::*;

   logic [2:0] funct3;
   logic [1:0] quadrant;
   // Full register fields, bits 11:7 and 6:2
   logic [reg_addr_width_c-1:0] rd_full;
   logic [reg_addr_width_c-1:0] rs2_full;
   // Prime registers map onto x8..x15
   logic [reg_addr_width_c-1:0] rd_prime;
   logic [reg_addr_width_c-1:0] rs1_prime;
   logic [11:0] ci_imm;
   logic [11:0] lw_imm;
   logic [20:0] j_imm;
   logic [12:0] b_imm;

   assign quadrant = instr_i[1:0];
   assign funct3 = instr_i[15:13];
   assign rd_full = instr_i[11:7];
   assign rs2_full = instr_i[6:2];
   assign rd_prime = {2'b01, instr_i[4:2]};
   assign rs1_prime = {2'b01, instr_i[9:7]};

   // Anything not ending in 2'b11 is a 16-bit encoding
   assign is_compressed_o = (quadrant != 2'b11);

   // C.ADDI / C.LI immediate, 6 bits sign-extended
   assign ci_imm = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};

   // C.LW / C.SW word offset, zero-extended
   assign lw_imm = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00};

   // C.J offset scrambled across bits 12:2
   assign j_imm = {{9{instr_i[12]}}, instr_i[12], instr_i[8], instr_i[10:9],
                   instr_i[6], instr_i[7], instr_i[2], instr_i[11],
                   instr_i[5:3], 1'b0};

   // C.BEQZ offset
   assign b_imm = {{4{instr_i[12]}}, instr_i[12], instr_i[6:5], instr_i[2],
                   instr_i[11:10], instr_i[4:3], 1'b0};

   always_comb
   begin
      // Unsupported compressed encodings come out as zero
      expanded_instr_o = '0;
      if (!is_compressed_o)
      begin
         expanded_instr_o = instr_i;
      end
      else
      begin
         case ({quadrant, funct3})
            // C.LW, lw rd', off(rs1')
            5'b00_010:
               expanded_instr_o = {lw_imm, rs1_prime, 3'b010, rd_prime, e_op_load};
            // C.SW, sw rs2', off(rs1')
            5'b00_110:
               expanded_instr_o = {lw_imm[11:5], rd_prime, rs1_prime, 3'b010,
                                   lw_imm[4:0], e_op_store};
            // C.ADDI, addi rd, rd, imm
            5'b01_000:
               expanded_instr_o = {ci_imm, rd_full, 3'b000, rd_full, e_op_imm};
            // C.LI, addi rd, x0, imm
            5'b01_010:
               expanded_instr_o = {ci_imm, 5'd0, 3'b000, rd_full, e_op_imm};
            5'b01_011:
            begin
               // rd of x2 is C.ADDI16SP, left out
               if (rd_full != 5'd2)
                  expanded_instr_o = {{14{instr_i[12]}}, instr_i[12], instr_i[6:2],
                                      rd_full, e_op_lui};
            end
            // C.J, jal x0, off
            5'b01_101:
               expanded_instr_o = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12],
                                   5'd0, e_op_jal};
            // C.BEQZ, beq rs1', x0, off
            5'b01_110:
               expanded_instr_o = {b_imm[12], b_imm[10:5], 5'd0, rs1_prime, 3'b000,
                                   b_imm[4:1], b_imm[11], e_op_branch};
            5'b10_100:
            begin
               // rs2 of x0 selects jr/jalr/ebreak, not handled
               if (rs2_full != 5'd0)
               begin
                  if (instr_i[12])
                     expanded_instr_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, e_op_op};
                  else
                     expanded_instr_o = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, e_op_op};
               end
            end
            default:
               expanded_instr_o = '0;
         endcase
      end
   end

endmodule

// ==== design/operand_decoder.sv ====
/*
 * Integer source predecode on the expanded instruction.
 * Tells the pipe which register file ports an instruction reads.
 */
`timescale 1ns/100ps

module operand_decoder
(
   input  logic [be_pkg::instr_width_c-1:0] instr_i,
   output be_pkg::src_info_s                src_info_o
);

   import be_pkg::*;

   rv64_opcode_e opcode;

   assign opcode = rv64_opcode_e'(instr_i[6:0]);

   // Register fields sit at fixed positions in every format
   assign src_info_o.rs1_addr = instr_i[19:15];
   assign src_info_o.rs2_addr = instr_i[24:20];

   always_comb
   begin
      case (opcode)
         // U and J formats, no sources
         e_op_lui, e_op_auipc, e_op_jal:
         begin
            src_info_o.irs1_v = 1'b0;
            src_info_o.irs2_v = 1'b0;
         end
         // rs1 only
         e_op_jalr, e_op_load, e_op_imm, e_op_imm_32, e_op_system:
         begin
            src_info_o.irs1_v = 1'b1;
            src_info_o.irs2_v = 1'b0;
         end
         // Both sources
         e_op_branch, e_op_store, e_op_op, e_op_op_32:
         begin
            src_info_o.irs1_v = 1'b1;
            src_info_o.irs2_v = 1'b1;
         end
         default:
         begin
            // Unknown opcode, keep both ports idle
            src_info_o.irs1_v = 1'b0;
            src_info_o.irs2_v = 1'b0;
         end
      endcase
   end

endmodule

// ==== design/imm_extractor.sv ====
/*
 * Picks the immediate format from the opcode and sign-extends it.
 * Output goes straight into the issue packet.
 */
`timescale 1ns/100ps

module imm_extractor
(
   input  logic [be_pkg::instr_width_c-1:0]    instr_i,
   output logic [be_pkg::reg_data_width_c-1:0] imm_o
);

   import be_pkg::*;

   rv64_opcode_e opcode;
   logic sign;

   assign opcode = rv64_opcode_e'(instr_i[6:0]);
   // Every format takes its sign from bit 31
   assign sign = instr_i[31];

   always_comb
   begin
      case (opcode)
         // U format, upper 20 bits
         e_op_lui, e_op_auipc:
            imm_o = {{(reg_data_width_c-32){sign}}, instr_i[31:12], 12'b0};
         // J format, bit 0 implied zero
         e_op_jal:
            imm_o = {{(reg_data_width_c-21){sign}}, instr_i[31], instr_i[19:12],
                     instr_i[20], instr_i[30:21], 1'b0};
         // B format
         e_op_branch:
            imm_o = {{(reg_data_width_c-13){sign}}, instr_i[31], instr_i[7],
                     instr_i[30:25], instr_i[11:8], 1'b0};
         // S format, split across funct7 and rd fields
         e_op_store:
            imm_o = {{(reg_data_width_c-12){sign}}, instr_i[31:25], instr_i[11:7]};
         // I format
         e_op_jalr, e_op_load, e_op_imm, e_op_imm_32:
            imm_o = {{(reg_data_width_c-12){sign}}, instr_i[31:20]};
         default:
            imm_o = '0;
      endcase
   end

endmodule

// ==== design/issue_scheduler.sv ====
/*
 * Builds the issue packet and holds it in a single output register.
 * Owns both valid/ready handshakes, the itag counter and redirect flush.
 */
`timescale 1ns/100ps

module issue_scheduler
(
   input  logic                                clk_i,
   input  logic                                arst_n_i,

   input  be_pkg::fe_queue_s                   fe_queue_i,
   input  logic                                fe_queue_v_i,
   output logic                                fe_queue_ready_o,

   input  logic [be_pkg::instr_width_c-1:0]    expanded_instr_i,
   input  logic                                is_compressed_i,
   input  be_pkg::src_info_s                   src_info_i,
   input  logic [be_pkg::reg_data_width_c-1:0] imm_i,

   input  logic                                pc_redirect_i,
   output be_pkg::issue_pkt_s                  issue_pkt_o,
   output logic                                issue_pkt_v_o,
   input  logic                                issue_pkt_ready_i
);

   import be_pkg::*;

   issue_pkt_s pkt_n;
   issue_pkt_s pkt_r;
   logic pkt_v_r;
   logic [itag_width_c-1:0] itag_r;
   logic accept;
   logic issue_done;

   // Held packet leaves this cycle
   assign issue_done = pkt_v_r & issue_pkt_ready_i;

   // Take a new message when empty or draining, never during a redirect
   assign fe_queue_ready_o = ~pc_redirect_i & (~pkt_v_r | issue_pkt_ready_i);
   assign accept = fe_queue_v_i & fe_queue_ready_o;

   always_comb
   begin
      pkt_n = '0;
      // Held packet owns itag_r, so a packet loaded behind it gets the next one
      pkt_n.instr_metadata.itag = itag_r + itag_width_c'(issue_done);
      if (fe_queue_i.msg_type == e_fe_exception)
      begin
         // Only the faulting address and code travel
         pkt_n.instr_metadata.pc = reg_data_width_c'($signed(fe_queue_i.pc));
         pkt_n.instr_metadata.exception_not_instr = 1'b1;
         pkt_n.instr_metadata.exc_code = fe_queue_i.exc_code;
      end
      else
      begin
         // Fetch PC zero-extended, as the front end hands it over
         pkt_n.instr_metadata.pc = reg_data_width_c'(fe_queue_i.pc);
         pkt_n.branch_metadata = fe_queue_i.branch_metadata;
         pkt_n.instr = expanded_instr_i;
         pkt_n.is_compressed = is_compressed_i;
         pkt_n.irs1_v = src_info_i.irs1_v;
         pkt_n.irs2_v = src_info_i.irs2_v;
         pkt_n.rs1_addr = src_info_i.rs1_addr;
         pkt_n.rs2_addr = src_info_i.rs2_addr;
         pkt_n.imm = imm_i;
      end
   end

   // Valid bit and itag counter
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         pkt_v_r <= 1'b0;
         itag_r <= '0;
      end
      else
      begin
         // Redirect drops whatever is held
         if (pc_redirect_i)
            pkt_v_r <= 1'b0;
         else if (accept)
            pkt_v_r <= 1'b1;
         else if (issue_done)
            pkt_v_r <= 1'b0;

         // Counts completed issues only
         if (issue_done)
            itag_r <= itag_r + 1'b1;
      end
   end

   // Payload, loaded on acceptance only
   always_ff @(posedge clk_i)
   begin
      if (accept)
         pkt_r <= pkt_n;
   end

   assign issue_pkt_o = pkt_r;
   assign issue_pkt_v_o = pkt_v_r;

endmodule

// ==== design/be_issue_top.sv ====
/*
 * Issue stage top level.
 * Expander feeds both decoders, the scheduler registers the packet.
 */
`timescale 1ns/100ps

module be_issue_top
(
   input  logic               clk_i,
   input  logic               arst_n_i,

   input  be_pkg::fe_queue_s  fe_queue_i,
   input  logic               fe_queue_v_i,
   output logic               fe_queue_ready_o,

   input  logic               pc_redirect_i,

   output be_pkg::issue_pkt_s issue_pkt_o,
   output logic               issue_pkt_v_o,
   input  logic               issue_pkt_ready_i
);

   import be_pkg::*;

   logic [instr_width_c-1:0] expanded_instr;
   logic is_compressed;
   src_info_s src_info;
   logic [reg_data_width_c-1:0] imm;

   // RVC to 32-bit
   rvc_expander u_rvc_expander
   (
      .instr_i          (fe_queue_i.instr),
      .expanded_instr_o (expanded_instr),
      .is_compressed_o  (is_compressed)
   );

   // Source predecode and immediate run side by side
   operand_decoder u_operand_decoder
   (
      .instr_i    (expanded_instr),
      .src_info_o (src_info)
   );

   imm_extractor u_imm_extractor
   (
      .instr_i (expanded_instr),
      .imm_o   (imm)
   );

   issue_scheduler u_issue_scheduler
   (
      .clk_i             (clk_i),
      .arst_n_i          (arst_n_i),
      .fe_queue_i        (fe_queue_i),
      .fe_queue_v_i      (fe_queue_v_i),
      .fe_queue_ready_o  (fe_queue_ready_o),
      .expanded_instr_i  (expanded_instr),
      .is_compressed_i   (is_compressed),
      .src_info_i        (src_info),
      .imm_i             (imm),
      .pc_redirect_i     (pc_redirect_i),
      .issue_pkt_o       (issue_pkt_o),
      .issue_pkt_v_o     (issue_pkt_v_o),
      .issue_pkt_ready_i (issue_pkt_ready_i)
   );

endmodule

// ==== testbench/be_issue_props.sv ====
/*
 * Concurrent checks on the issue stage handshake and reset.
 * Bound into be_issue_top by the bind at the bottom.
 */
`timescale 1ns/100ps

module be_issue_props
(
   input logic               clk_i,
   input logic               arst_n_i,
   input logic               fe_queue_ready_o,
   input logic               pc_redirect_i,
   input be_pkg::issue_pkt_s issue_pkt_o,
   input logic               issue_pkt_v_o,
   input logic               issue_pkt_ready_i
);

   // Stalled packet frozen unless flushed
   stall_stable_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      issue_pkt_v_o && !issue_pkt_ready_i && !pc_redirect_i
      |=> issue_pkt_v_o && $stable(issue_pkt_o))
   else
      $error("issue packet changed or dropped while stalled");

   // Nothing valid in reset or on the first edge out of it
   reset_idle_a : assert property (@(posedge clk_i)
      !arst_n_i || $rose(arst_n_i) |-> !issue_pkt_v_o)
   else
      $error("issue valid high around reset");

   redirect_block_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      pc_redirect_i |-> !fe_queue_ready_o)
   else
      $error("queue ready high during redirect");

endmodule

bind be_issue_top be_issue_props props_i (.*);

// ==== testbench/be_issue_ref.svh ====
/*
 * Reference model of the issue stage, built from the RISC-V encodings.
 * Included inside the testbench module, after the package import.
 */
`ifndef BE_ISSUE_REF_SVH
`define BE_ISSUE_REF_SVH

// 16-bit encodings to their 32-bit forms, unsupported ones to zero
function automatic logic [31:0] expand_rvc(input logic [31:0] raw);
   logic [15:0] c;
   logic [4:0] rd;
   logic [4:0] rs2;
   logic [4:0] rdp;
   logic [4:0] rs1p;
   logic [11:0] ci;
   logic [11:0] woff;
   logic [20:0] joff;
   logic [12:0] boff;
   c = raw[15:0];
   rd = c[11:7];
   rs2 = c[6:2];
   rdp = 5'd8 + 5'(c[4:2]);
   rs1p = 5'd8 + 5'(c[9:7]);
   ci = 12'($signed({c[12], c[6:2]}));
   // Word offset bits 6, 5:3, 2
   woff = {5'b0, c[5], c[12:10], c[6], 2'b00};
   // Jump offset bits 11, 10, 9:8, 7, 6, 5, 4, 3:1
   joff = 21'($signed({c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0}));
   // Branch offset bits 8, 7:6, 5, 4:3, 2:1
   boff = 13'($signed({c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0}));
   if (raw[1:0] == 2'b11)
      return raw;
   case ({c[1:0], c[15:13]})
      5'b00010:
         return {woff, rs1p, 3'b010, rdp, 7'b0000011};
      5'b00110:
         return {woff[11:5], rdp, rs1p, 3'b010, woff[4:0], 7'b0100011};
      5'b01000:
         return {ci, rd, 3'b000, rd, 7'b0010011};
      5'b01010:
         return {ci, 5'd0, 3'b000, rd, 7'b0010011};
      // rd of x2 would be C.ADDI16SP
      5'b01011:
         return (rd == 5'd2) ? 32'd0 : {20'($signed({c[12], c[6:2]})), rd, 7'b0110111};
      5'b01101:
         return {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, 7'b1101111};
      5'b01110:
         return {boff[12], boff[10:5], 5'd0, rs1p, 3'b000, boff[4:1], boff[11], 7'b1100011};
      // C.MV when bit 12 clear, C.ADD when set
      5'b10100:
         return (rs2 == 5'd0) ? 32'd0 : {7'd0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'b0110011};
      default:
         return 32'd0;
   endcase
endfunction

function automatic src_info_s predecode_sources(input logic [31:0] ins);
   src_info_s s;
   s.rs1_addr = ins[19:15];
   s.rs2_addr = ins[24:20];
   s.irs1_v = 1'b0;
   s.irs2_v = 1'b0;
   case (ins[6:0])
      // JALR, LOAD, OP_IMM, OP_IMM_32, SYSTEM
      7'b1100111, 7'b0000011, 7'b0010011, 7'b0011011, 7'b1110011:
         s.irs1_v = 1'b1;
      // BRANCH, STORE, OP, OP_32
      7'b1100011, 7'b0100011, 7'b0110011, 7'b0111011:
      begin
         s.irs1_v = 1'b1;
         s.irs2_v = 1'b1;
      end
      default:
         s.irs1_v = 1'b0;
   endcase
   return s;
endfunction

function automatic logic [63:0] extract_imm(input logic [31:0] ins);
   case (ins[6:0])
      7'b0110111, 7'b0010111:
         return 64'($signed({ins[31:12], 12'd0}));
      7'b1101111:
         return 64'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
      7'b1100011:
         return 64'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
      7'b0100011:
         return 64'($signed({ins[31:25], ins[11:7]}));
      7'b1100111, 7'b0000011, 7'b0010011, 7'b0011011:
         return 64'($signed(ins[31:20]));
      default:
         return 64'd0;
   endcase
endfunction

// Expected packet for one accepted message
function automatic issue_pkt_s build_packet(input fe_queue_s msg, input logic [7:0] itag);
   issue_pkt_s p;
   src_info_s s;
   p = '0;
   p.instr_metadata.itag = itag;
   if (msg.msg_type == e_fe_exception)
   begin
      p.instr_metadata.pc = 64'($signed(msg.pc));
      p.instr_metadata.exception_not_instr = 1'b1;
      p.instr_metadata.exc_code = msg.exc_code;
   end
   else
   begin
      // Fetch PC enters zero-extended
      p.instr_metadata.pc = {25'd0, msg.pc};
      p.branch_metadata = msg.branch_metadata;
      p.instr = expand_rvc(msg.instr);
      p.is_compressed = (msg.instr[1:0] != 2'b11);
      s = predecode_sources(p.instr);
      p.irs1_v = s.irs1_v;
      p.irs2_v = s.irs2_v;
      p.rs1_addr = s.rs1_addr;
      p.rs2_addr = s.rs2_addr;
      p.imm = extract_imm(p.instr);
   end
   return p;
endfunction

`endif

// ==== testbench/be_issue_tb.sv ====
/*
 * Testbench for the issue stage with directed and LFSR-driven traffic.
 * Expected packets queue up on acceptance and are compared on issue.
 */
`timescale 1ns/100ps

module be_issue_tb;

   import be_pkg::*;

   logic clk_i;
   logic arst_n_i;
   fe_queue_s fe_queue_i;
   logic fe_queue_v_i;
   logic fe_queue_ready_o;
   logic pc_redirect_i;
   issue_pkt_s issue_pkt_o;
   logic issue_pkt_v_o;
   logic issue_pkt_ready_i;

   logic [31:0] lfsr;
   issue_pkt_s expected_q[$];
   int issue_count = 0;
   int mismatch_count = 0;
   int other_errors = 0;
   int wait_limit = 100;

   // One per opcode class
   logic [31:0] full_instrs [12] = '{
      32'hfffff2b7, 32'h12345097, 32'h8000006f, 32'hfe0080e7,
      32'hfe208ce3, 32'hff813083, 32'hfe312e23, 32'h80010093,
      32'h0015051b, 32'h40b50533, 32'h00b5053b, 32'h00000073};
   // Supported RVC forms plus C.BNEZ, then C.ADDI16SP, ret and the all-zero word
   logic [15:0] rvc_instrs [13] = '{
      16'h157d, 16'h4515, 16'h6585, 16'hf5fd, 16'h4188, 16'hc1c8, 16'hbffd,
      16'hc119, 16'h852e, 16'h952e, 16'h6105, 16'h8082, 16'h0000};
   // Last entry is not a real major opcode
   logic [6:0] major_ops [13] = '{
      7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011, 7'b0000011,
      7'b0100011, 7'b0010011, 7'b0011011, 7'b0110011, 7'b0111011, 7'b1110011,
      7'b1111111};

   `include "be_issue_ref.svh"

   be_issue_top dut_i (.*);

   initial
   begin
      clk_i = 1'b0;
      forever
         #2 clk_i = ~clk_i;
   end

   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      logic fb;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic fe_queue_s fetch_msg(input logic [31:0] instr);
      fe_queue_s m;
      m = '0;
      m.msg_type = e_fe_fetch;
      m.pc = 39'({take_bits(7), take_bits(32)});
      m.instr = instr;
      m.branch_metadata = take_bits(32);
      return m;
   endfunction

   function automatic fe_queue_s exception_msg(input logic [38:0] pc, input fe_exc_code_e code);
      fe_queue_s m;
      m = '0;
      m.msg_type = e_fe_exception;
      m.pc = pc;
      m.exc_code = code;
      // Junk that must not reach the packet
      m.instr = take_bits(32);
      m.branch_metadata = take_bits(32);
      return m;
   endfunction

   function automatic fe_queue_s random_msg();
      fe_queue_s m;
      logic [4:0] pick;
      logic [1:0] code;
      pick = 5'(take_bits(5));
      code = 2'(take_bits(2));
      m = fetch_msg(take_bits(32));
      if (pick < 5'd2)
         m = exception_msg(m.pc, fe_exc_code_e'(code));
      else if (pick < 5'd12)
      begin
         // Force a 16-bit encoding
         if (m.instr[1:0] == 2'b11)
            m.instr[1:0] = 2'b01;
      end
      else
         m.instr[6:0] = major_ops[pick % 5'd13];
      return m;
   endfunction

   task automatic end_run();
      $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_errors);
      if (mismatch_count == 0 && other_errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   endtask

   task automatic time_out(input string what);
      other_errors++;
      $display("Timeout at %0t waiting for %s", $time, what);
      end_run();
   endtask

   task automatic compare_field(input string name, input logic [63:0] got,
                                input logic [63:0] want);
      assert (got === want)
      else
      begin
         mismatch_count++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
      end
   endtask

   task automatic check_packet(input issue_pkt_s want);
      compare_field("issue_pkt_o.itag", 64'(issue_pkt_o.instr_metadata.itag),
                    64'(want.instr_metadata.itag));
      compare_field("issue_pkt_o.pc", issue_pkt_o.instr_metadata.pc, want.instr_metadata.pc);
      compare_field("issue_pkt_o.instr", 64'(issue_pkt_o.instr), 64'(want.instr));
      compare_field("issue_pkt_o.imm", issue_pkt_o.imm, want.imm);
      // Whole packet catches the flag and address fields
      assert (issue_pkt_o === want)
      else
      begin
         mismatch_count++;
         $display("Mismatch at %0t: issue_pkt_o got %h expected %h", $time, issue_pkt_o, want);
      end
   endtask

   // Scoreboard compares on issue, drops on flush and pushes on acceptance
   always @(posedge clk_i)
   begin
      issue_pkt_s want;
      if (arst_n_i)
      begin
         if (issue_pkt_v_o && issue_pkt_ready_i)
         begin
            assert (expected_q.size() != 0)
            else
            begin
               other_errors++;
               $display("Error at %0t: packet issued with nothing expected", $time);
            end
            if (expected_q.size() != 0)
            begin
               want = expected_q.pop_front();
               check_packet(want);
            end
            issue_count++;
         end
         if (pc_redirect_i && issue_pkt_v_o && !issue_pkt_ready_i && expected_q.size() != 0)
            void'(expected_q.pop_back());
         // Itag follows the count of completed issues
         if (fe_queue_v_i && fe_queue_ready_o)
            expected_q.push_back(build_packet(fe_queue_i, 8'(issue_count)));
      end
   end

   task automatic wait_accept();
      logic done;
      int cycles;
      done = 1'b0;
      cycles = 0;
      while (!done && cycles < wait_limit)
      begin
         @(posedge clk_i);
         cycles++;
         done = fe_queue_v_i && fe_queue_ready_o;
      end
      assert (done)
      else
         time_out("message acceptance");
   endtask

   task automatic wait_issue(output int cycles);
      logic done;
      done = 1'b0;
      cycles = 0;
      while (!done && cycles < wait_limit)
      begin
         @(posedge clk_i);
         cycles++;
         done = issue_pkt_v_o && issue_pkt_ready_i;
      end
      assert (done)
      else
         time_out("issue transfer");
   endtask

   // One message through with ready high and a one-cycle latency
   task automatic issue_directed(input fe_queue_s msg);
      int cycles;
      @(negedge clk_i);
      fe_queue_i = msg;
      fe_queue_v_i = 1'b1;
      wait_accept();
      @(negedge clk_i);
      fe_queue_v_i = 1'b0;
      wait_issue(cycles);
      assert (cycles == 1)
      else
      begin
         other_errors++;
         $display("Error at %0t: issue took %0d cycles instead of 1", $time, cycles);
      end
   endtask

   // Stall a packet, flush it, then release the issue side
   task automatic redirect_held(input fe_queue_s msg);
      @(negedge clk_i);
      issue_pkt_ready_i = 1'b0;
      fe_queue_i = msg;
      fe_queue_v_i = 1'b1;
      wait_accept();
      @(negedge clk_i);
      fe_queue_v_i = 1'b0;
      pc_redirect_i = 1'b1;
      @(posedge clk_i);
      assert (!fe_queue_ready_o)
      else
      begin
         other_errors++;
         $display("Error at %0t: queue ready high during redirect", $time);
      end
      @(negedge clk_i);
      pc_redirect_i = 1'b0;
      issue_pkt_ready_i = 1'b1;
      assert (!issue_pkt_v_o)
      else
      begin
         other_errors++;
         $display("Error at %0t: held packet survived the redirect", $time);
      end
   endtask

   task automatic random_traffic(input int cycles);
      logic accepted;
      for (int c = 0; c < cycles; c++)
      begin
         @(posedge clk_i);
         accepted = fe_queue_v_i && fe_queue_ready_o;
         @(negedge clk_i);
         issue_pkt_ready_i = (take_bits(2) != 0);
         // Offered message stays until taken
         if (!fe_queue_v_i || accepted)
         begin
            fe_queue_v_i = (take_bits(2) != 0);
            fe_queue_i = random_msg();
         end
      end
   endtask

   initial
   begin
      int cycles;
      lfsr = 32'd80868;
      arst_n_i = 1'b0;
      fe_queue_i = '0;
      fe_queue_v_i = 1'b0;
      pc_redirect_i = 1'b0;
      issue_pkt_ready_i = 1'b1;
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;

      foreach (full_instrs[k])
         issue_directed(fetch_msg(full_instrs[k]));
      foreach (rvc_instrs[k])
         issue_directed(fetch_msg({16'h0000, rvc_instrs[k]}));
      // Bit 38 set and clear for the sign extension
      issue_directed(exception_msg(39'h40_0000_1234, e_itlb_miss));
      issue_directed(exception_msg(39'h00_1234_5678, e_instr_page_fault));
      issue_directed(exception_msg(39'h7f_ffff_fffe, e_instr_misaligned));

      redirect_held(fetch_msg(full_instrs[9]));
      issue_directed(fetch_msg(full_instrs[4]));

      random_traffic(800);

      // Let the last offer go in, then empty the register
      issue_pkt_ready_i = 1'b1;
      if (fe_queue_v_i)
         wait_accept();
      @(negedge clk_i);
      fe_queue_v_i = 1'b0;
      if (issue_pkt_v_o)
         wait_issue(cycles);
      @(negedge clk_i);
      assert (expected_q.size() == 0 && !issue_pkt_v_o)
      else
      begin
         other_errors++;
         $display("Error at %0t: %0d accepted packets never issued", $time, expected_q.size());
      end
      end_run();
   end

endmodule

// ==== sources.f ====
+incdir+testbench
design/be_pkg.sv
design/rvc_expander.sv
design/operand_decoder.sv
design/imm_extractor.sv
design/issue_scheduler.sv
design/be_issue_top.sv
testbench/be_issue_props.sv
testbench/be_issue_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = be_issue_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build, run, then decide on the pass line in the log
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
